//--- Makefile
# Verilator build and run of the cache bridge testbench.

VERILATOR ?= verilator
TOP       ?= fml_cache_tb
FILELIST  ?= fml_cache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

# the run passes only if the pass line shows up in the output.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/fml_cache_tb.sv
// Cache bridge testbench
`timescale 1ns/100ps

module fml_cache_tb;

  localparam int          TABLE_LEN  = 22;
  localparam logic [31:0] SEED       = 32'h7324_e3f0;
  localparam int          RANDOM_LEN = 200;

  // worst case access is an evict and a refill with full delay.
  localparam int WATCHDOG_CYCLES = (TABLE_LEN + RANDOM_LEN) * 40;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_INV} op_t;

  typedef struct {
    op_t                    op;
    fml_cache_pkg::wb_adr_t adr;
    fml_cache_pkg::sel_t    sel;
    fml_cache_pkg::word_t   dat;
    fml_cache_pkg::word_t   exp_dat;
    int                     exp_rd;
    int                     exp_wr;
  } step_t;

  logic                     sys_clk;
  logic                     sys_rst;
  fml_cache_pkg::wb_adr_t   wb_adr_i;
  fml_cache_pkg::word_t     wb_dat_i;
  fml_cache_pkg::sel_t      wb_sel_i;
  logic                     wb_we_i;
  logic                     wb_tga_i;
  logic                     wb_cyc_i;
  logic                     wb_stb_i;
  fml_cache_pkg::word_t     wb_dat_o;
  logic                     wb_ack_o;
  fml_cache_pkg::fml_adr_t  fml_adr;
  logic                     fml_stb;
  logic                     fml_we;
  fml_cache_pkg::word_t     fml_do;
  logic                     fml_ack;
  fml_cache_pkg::word_t     fml_di;
  int                       read_bursts;
  int                       write_bursts;

  step_t                    steps [TABLE_LEN];
  fml_cache_pkg::word_t     shadow [0:(1 << (fml_cache_pkg::FML_DEPTH - 1)) - 1];
  int                       checks;
  int                       errors;

  tb_clock_gen clock_gen_inst (
    .sys_clk_o (sys_clk),
    .sys_rst_o (sys_rst)
  );

  fml_cache_top fml_cache_top_inst (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_we_i   (wb_we_i),
    .wb_tga_i  (wb_tga_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .fml_adr_o (fml_adr),
    .fml_stb_o (fml_stb),
    .fml_we_o  (fml_we),
    .fml_do_o  (fml_do),
    .fml_ack_i (fml_ack),
    .fml_di_i  (fml_di)
  );

  fml_mem_model mem_model_inst (
    .sys_clk        (sys_clk),
    .sys_rst        (sys_rst),
    .fml_adr_i      (fml_adr),
    .fml_stb_i      (fml_stb),
    .fml_we_i       (fml_we),
    .fml_dat_i      (fml_do),
    .fml_ack_o      (fml_ack),
    .fml_dat_o      (fml_di),
    .read_bursts_o  (read_bursts),
    .write_bursts_o (write_bursts)
  );

  task automatic set_step(input int idx, input op_t op, input fml_cache_pkg::wb_adr_t adr,
                          input fml_cache_pkg::sel_t sel, input fml_cache_pkg::word_t dat,
                          input fml_cache_pkg::word_t exp_dat, input int rd, input int wr);
    steps[idx] = '{op, adr, sel, dat, exp_dat, rd, wr};
  endtask

  // lines A and B share index 4, tags 1 and 2.
  // burst counts are running totals after each step.
  task automatic load_table();
    set_step(0,  OP_READ,  15'h0120, 2'b00, 16'h0000, 16'h581a, 1, 0);
    set_step(1,  OP_READ,  15'h0123, 2'b00, 16'h0000, 16'h581c, 1, 0);
    set_step(2,  OP_WRITE, 15'h0120, 2'b01, 16'h1234, 16'h0000, 1, 0);
    set_step(3,  OP_READ,  15'h0120, 2'b00, 16'h0000, 16'h5834, 1, 0);
    set_step(4,  OP_WRITE, 15'h0120, 2'b10, 16'habcd, 16'h0000, 1, 0);
    set_step(5,  OP_READ,  15'h0120, 2'b00, 16'h0000, 16'hab34, 1, 0);
    set_step(6,  OP_WRITE, 15'h0123, 2'b11, 16'hbeef, 16'h0000, 1, 0);
    set_step(7,  OP_READ,  15'h0123, 2'b00, 16'h0000, 16'hbeef, 1, 0);
    set_step(8,  OP_WRITE, 15'h0120, 2'b00, 16'hffff, 16'h0000, 1, 0);
    set_step(9,  OP_READ,  15'h0120, 2'b00, 16'h0000, 16'hab34, 1, 0);
    // conflict miss on the dirty line, critical word 5.
    set_step(10, OP_READ,  15'h0225, 2'b00, 16'h0000, 16'h5e10, 2, 1);
    set_step(11, OP_READ,  15'h0120, 2'b00, 16'h0000, 16'hab34, 3, 1);
    set_step(12, OP_READ,  15'h0123, 2'b00, 16'h0000, 16'hbeef, 3, 1);
    set_step(13, OP_WRITE, 15'h0123, 2'b11, 16'h0f0f, 16'h0000, 3, 1);
    set_step(14, OP_INV,   15'h0120, 2'b00, 16'h0000, 16'h0000, 3, 2);
    set_step(15, OP_READ,  15'h0123, 2'b00, 16'h0000, 16'h0f0f, 4, 2);
    set_step(16, OP_READ,  15'h0120, 2'b00, 16'h0000, 16'hab34, 4, 2);
    // clean invalidate costs no burst.
    set_step(17, OP_INV,   15'h0120, 2'b00, 16'h0000, 16'h0000, 4, 2);
    set_step(18, OP_READ,  15'h0120, 2'b00, 16'h0000, 16'hab34, 5, 2);
    set_step(19, OP_WRITE, 15'h0220, 2'b01, 16'h7788, 16'h0000, 6, 2);
    set_step(20, OP_READ,  15'h0220, 2'b00, 16'h0000, 16'h5e88, 6, 2);
    set_step(21, OP_READ,  15'h0123, 2'b00, 16'h0000, 16'h0f0f, 7, 3);
  endtask

  // one wishbone request, held until the acknowledge is seen.
  task automatic run_access(input op_t op, input fml_cache_pkg::wb_adr_t adr,
                            input fml_cache_pkg::sel_t sel, input fml_cache_pkg::word_t dat,
                            output fml_cache_pkg::word_t rdata);
    @(posedge sys_clk);
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    wb_we_i  <= (op == OP_WRITE);
    wb_tga_i <= (op == OP_INV);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    @(posedge sys_clk);
    while (!wb_ack_o) begin
      @(posedge sys_clk);
    end
    rdata = wb_dat_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_tga_i <= 1'b0;
  endtask

  // shadow copy of a byte lane write.
  task automatic shadow_write(input fml_cache_pkg::wb_adr_t adr,
                              input fml_cache_pkg::sel_t sel, input fml_cache_pkg::word_t dat);
    for (int lane = 0; lane < 2; lane++) begin
      if (sel[lane]) begin
        shadow[adr][lane*8 +: 8] = dat[lane*8 +: 8];
      end
    end
  endtask

  task automatic check_word(input string name, input fml_cache_pkg::word_t got,
                            input fml_cache_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  initial begin : main
    fml_cache_pkg::word_t   rdata;
    fml_cache_pkg::wb_adr_t adr;
    fml_cache_pkg::tag_t    tag;
    fml_cache_pkg::index_t  index;
    fml_cache_pkg::offset_t offset;
    fml_cache_pkg::sel_t    sel;
    fml_cache_pkg::word_t   dat;
    int                     pick;
    void'($urandom(SEED));
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_tga_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    checks   = 0;
    errors   = 0;
    // byte address xor 5a5a, as the memory starts out.
    for (int i = 0; i < (1 << (fml_cache_pkg::FML_DEPTH - 1)); i++) begin
      shadow[i] = {i[fml_cache_pkg::FML_DEPTH-2:0], 1'b0} ^ 16'h5a5a;
    end
    load_table();
    wait (!sys_rst);
    for (int i = 0; i < TABLE_LEN; i++) begin
      run_access(steps[i].op, steps[i].adr, steps[i].sel, steps[i].dat, rdata);
      if (steps[i].op == OP_READ) begin
        check_word($sformatf("wb_dat_o step %0d", i), rdata, steps[i].exp_dat);
      end else if (steps[i].op == OP_WRITE) begin
        shadow_write(steps[i].adr, steps[i].sel, steps[i].dat);
      end
      check_count($sformatf("read_bursts step %0d", i), read_bursts, steps[i].exp_rd);
      check_count($sformatf("write_bursts step %0d", i), write_bursts, steps[i].exp_wr);
    end
    // few tags and indexes, so hits, evicts and refills all show up.
    for (int n = 0; n < RANDOM_LEN; n++) begin
      tag    = fml_cache_pkg::tag_t'($urandom % 4);
      index  = fml_cache_pkg::index_t'($urandom % 4);
      offset = fml_cache_pkg::offset_t'($urandom);
      adr    = {tag, index, offset};
      sel    = fml_cache_pkg::sel_t'($urandom);
      dat    = fml_cache_pkg::word_t'($urandom);
      pick   = $urandom % 10;
      if (pick < 5) begin
        run_access(OP_READ, adr, sel, dat, rdata);
        check_word($sformatf("wb_dat_o adr %h", adr), rdata, shadow[adr]);
      end else if (pick < 9) begin
        run_access(OP_WRITE, adr, sel, dat, rdata);
        shadow_write(adr, sel, dat);
      end else begin
        run_access(OP_INV, adr, sel, dat, rdata);
      end
    end
    $display("checks %0d errors %0d read bursts %0d write bursts %0d",
             checks, errors, read_bursts, write_bursts);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
    $display("watchdog expired after %0d cycles, a request was never acknowledged",
             WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- bench/fml_mem_model.sv
// FML burst memory model
`timescale 1ns/100ps

module fml_mem_model (
  input  logic                     sys_clk,
  input  logic                     sys_rst,
  input  fml_cache_pkg::fml_adr_t  fml_adr_i,
  input  logic                     fml_stb_i,
  input  logic                     fml_we_i,
  input  fml_cache_pkg::word_t     fml_dat_i,
  output logic                     fml_ack_o,
  output fml_cache_pkg::word_t     fml_dat_o,
  output int                       read_bursts_o,
  output int                       write_bursts_o
);

  // one word per even byte address.
  fml_cache_pkg::word_t mem [0:(1 << (fml_cache_pkg::FML_DEPTH - 1)) - 1];

  // burst in flight.
  fml_cache_pkg::fml_adr_t base_q;
  logic                    we_q;
  logic                    active_q;
  fml_cache_pkg::offset_t  beat_q;

  // acknowledge delay still to run.
  logic                    waiting_q;
  int                      delay_q;

  // word index of a beat, wrapping inside the line.
  function automatic fml_cache_pkg::wb_adr_t beat_word(
    input fml_cache_pkg::fml_adr_t base,
    input fml_cache_pkg::offset_t  beat
  );
    fml_cache_pkg::offset_t off;
    off = base[fml_cache_pkg::OFFSET_W:1] + beat;
    return {base[fml_cache_pkg::FML_DEPTH-1:fml_cache_pkg::OFFSET_W+1], off};
  endfunction

  // each word starts as its byte address xor 5a5a.
  initial begin
    fml_ack_o = 1'b0;
    fml_dat_o = '0;
    for (int i = 0; i < (1 << (fml_cache_pkg::FML_DEPTH - 1)); i++) begin
      mem[i] = {i[fml_cache_pkg::FML_DEPTH-2:0], 1'b0} ^ 16'h5a5a;
    end
  end

  always @(posedge sys_clk) begin : burst_engine
    int left;
    if (sys_rst) begin
      fml_ack_o      <= 1'b0;
      active_q       <= 1'b0;
      waiting_q      <= 1'b0;
      delay_q        <= 0;
      beat_q         <= '0;
      read_bursts_o  <= 0;
      write_bursts_o <= 0;
    end else if (active_q) begin
      // beat_q moved in the cycle that just ended.
      fml_ack_o <= 1'b0;
      if (we_q) begin
        mem[beat_word(base_q, beat_q)] <= fml_dat_i;
      end
      if (beat_q == '1) begin
        active_q <= 1'b0;
      end else if (!we_q) begin
        fml_dat_o <= mem[beat_word(base_q, beat_q + 1'b1)];
      end
      beat_q <= beat_q + 1'b1;
    end else if (fml_stb_i) begin
      // draw a fresh 0 to 3 cycle delay per request.
      left = waiting_q ? delay_q : int'($urandom % 4);
      if (left == 0) begin
        waiting_q <= 1'b0;
        fml_ack_o <= 1'b1;
        active_q  <= 1'b1;
        beat_q    <= '0;
        base_q    <= fml_adr_i;
        we_q      <= fml_we_i;
        if (fml_we_i) begin
          write_bursts_o <= write_bursts_o + 1;
        end else begin
          read_bursts_o <= read_bursts_o + 1;
          fml_dat_o     <= mem[beat_word(fml_adr_i, '0)];
        end
      end else begin
        waiting_q <= 1'b1;
        delay_q   <= left - 1;
      end
    end
  end

endmodule

//--- bench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen (
  output logic sys_clk_o,
  output logic sys_rst_o
);

  // 40 ns period.
  initial begin
    sys_clk_o = 1'b0;
    forever #20 sys_clk_o = ~sys_clk_o;
  end

  // reset seen by three rising edges.
  initial begin
    sys_rst_o = 1'b1;
    repeat (3) @(posedge sys_clk_o);
    sys_rst_o <= 1'b0;
  end

endmodule

//--- design/fml_cache_ctrl.sv
// Cache controller
`timescale 1ns/100ps

module fml_cache_ctrl (
  input  logic                                   sys_clk,
  input  logic                                   sys_rst,

  input  fml_cache_pkg::wb_adr_t                 wb_adr_i,
  input  fml_cache_pkg::word_t                   wb_dat_i,
  input  fml_cache_pkg::sel_t                    wb_sel_i,
  input  logic                                   wb_we_i,
  input  logic                                   wb_tga_i,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  output fml_cache_pkg::word_t                   wb_dat_o,
  output logic                                   wb_ack_o,

  output fml_cache_pkg::fml_adr_t                fml_adr_o,
  output logic                                   fml_stb_o,
  output logic                                   fml_we_o,
  output fml_cache_pkg::word_t                   fml_do_o,
  input  logic                                   fml_ack_i,
  input  fml_cache_pkg::word_t                   fml_di_i,

  output fml_cache_pkg::index_t                  tag_adr_o,
  output logic                                   tag_we_o,
  output fml_cache_pkg::tag_entry_t              tag_wdata_o,
  input  fml_cache_pkg::tag_entry_t              tag_rdata_i,

  output logic [fml_cache_pkg::LINE_ADR_W-1:0]   data_adr_o,
  output logic                                   data_we_o,
  output fml_cache_pkg::word_t                   data_wdata_o,
  input  fml_cache_pkg::word_t                   data_rdata_i
);

  typedef enum logic [3:0] {
    ST_SWEEP,
    ST_IDLE,
    ST_TEST_HIT,
    ST_WRITE_HIT,
    ST_EVICT,
    ST_EVICT_RUN,
    ST_REFILL,
    ST_REFILL_RUN,
    ST_TEST_INV,
    ST_INVALIDATE
  } state_t;

  state_t state_q;
  state_t state_d;

  // fields of the live wishbone address.
  fml_cache_pkg::tag_t    req_tag;
  fml_cache_pkg::index_t  req_index;
  fml_cache_pkg::offset_t req_offset;

  // request copy taken while idle.
  fml_cache_pkg::tag_t    tag_q;
  fml_cache_pkg::index_t  index_q;
  fml_cache_pkg::offset_t offset_q;
  fml_cache_pkg::offset_t offset_last;

  // line index that the stores see.
  fml_cache_pkg::index_t  line_index;

  // tag clear sweep after reset.
  fml_cache_pkg::index_t  sweep_q;

  // burst counter, wraps within the line.
  fml_cache_pkg::offset_t bcnt_q;
  fml_cache_pkg::offset_t bcnt_inc;
  fml_cache_pkg::offset_t bcnt_next;
  logic                   bcnt_load;
  logic                   bcnt_en;

  logic                   hit;
  fml_cache_pkg::tag_t    fml_tag;

  // replace the selected byte lanes of a word.
  function automatic fml_cache_pkg::word_t merge_lanes(
    input fml_cache_pkg::word_t old_w,
    input fml_cache_pkg::word_t new_w,
    input fml_cache_pkg::sel_t  sel
  );
    fml_cache_pkg::word_t res;
    res = old_w;
    if (sel[0]) begin
      res[7:0] = new_w[7:0];
    end
    if (sel[1]) begin
      res[15:8] = new_w[15:8];
    end
    return res;
  endfunction

  // address split, tag | index | offset.
  assign req_offset = wb_adr_i[fml_cache_pkg::OFFSET_W-1:0];
  assign req_index  = wb_adr_i[fml_cache_pkg::OFFSET_W +: fml_cache_pkg::INDEX_W];
  assign req_tag    = wb_adr_i[fml_cache_pkg::LINE_ADR_W +: fml_cache_pkg::TAG_W];

  // hold the request while idle.
  // the live address may move once the request is acked mid refill.
  always_ff @(posedge sys_clk) begin
    if (state_q == ST_IDLE) begin
      tag_q    <= req_tag;
      index_q  <= req_index;
      offset_q <= req_offset;
    end
  end

  // last word of a refill burst sits just before the critical word.
  assign offset_last = offset_q - 1'b1;

  // idle reads from the live address, so a hit is known one cycle later.
  assign line_index = (state_q == ST_IDLE) ? req_index : index_q;

  // burst counter.
  assign bcnt_inc = bcnt_q + 1'b1;

  always_comb begin
    if (bcnt_load) begin
      bcnt_next = req_offset;
    end else if (bcnt_en) begin
      bcnt_next = bcnt_inc;
    end else begin
      bcnt_next = bcnt_q;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      bcnt_q <= '0;
    end else begin
      bcnt_q <= bcnt_next;
    end
  end

  // sweep counter runs only in the sweep state.
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      sweep_q <= '0;
    end else if (state_q == ST_SWEEP) begin
      sweep_q <= sweep_q + 1'b1;
    end
  end

  // store addresses.
  // the data address looks one step ahead so the read is ready in time.
  assign tag_adr_o  = (state_q == ST_SWEEP) ? sweep_q : line_index;
  assign data_adr_o = {line_index, bcnt_next};

  // compare against the tag copied at the sampling edge.
  assign hit = tag_rdata_i.valid && (tag_rdata_i.tag == tag_q);

  // evict goes to the victim line, refill to the requested one.
  assign fml_tag   = (state_q == ST_EVICT || state_q == ST_EVICT_RUN) ?
                     tag_rdata_i.tag : tag_q;
  assign fml_adr_o = {fml_tag, index_q, offset_q, 1'b0};

  // both outgoing data paths come straight from the data store.
  assign wb_dat_o = data_rdata_i;
  assign fml_do_o = data_rdata_i;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state_q <= ST_SWEEP;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    bcnt_load    = 1'b0;
    bcnt_en      = 1'b0;
    tag_we_o     = 1'b0;
    tag_wdata_o  = '0;
    data_we_o    = 1'b0;
    data_wdata_o = fml_di_i;
    wb_ack_o     = 1'b0;
    fml_stb_o    = 1'b0;
    fml_we_o     = 1'b0;

    unique case (state_q)
      ST_SWEEP: begin
        // clear one tag entry per cycle.
        tag_we_o = 1'b1;
        if (sweep_q == '1) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        bcnt_load = 1'b1;
        if (wb_cyc_i && wb_stb_i) begin
          state_d = wb_tga_i ? ST_TEST_INV : ST_TEST_HIT;
        end
      end
      ST_TEST_HIT: begin
        if (hit) begin
          if (wb_we_i) begin
            state_d = ST_WRITE_HIT;
          end else begin
            // read data is already on the store output.
            wb_ack_o = 1'b1;
            state_d  = ST_IDLE;
          end
        end else begin
          state_d = tag_rdata_i.dirty ? ST_EVICT : ST_REFILL;
        end
      end
      ST_WRITE_HIT: begin
        tag_we_o     = 1'b1;
        tag_wdata_o  = '{valid: 1'b1, dirty: 1'b1, tag: tag_q};
        data_we_o    = 1'b1;
        data_wdata_o = merge_lanes(data_rdata_i, wb_dat_i, wb_sel_i);
        wb_ack_o     = 1'b1;
        state_d      = ST_IDLE;
      end
      ST_EVICT: begin
        // beat 0 goes out with the acknowledge.
        fml_stb_o = 1'b1;
        fml_we_o  = 1'b1;
        if (fml_ack_i) begin
          bcnt_en = 1'b1;
          state_d = ST_EVICT_RUN;
        end
      end
      ST_EVICT_RUN: begin
        // seven more beats, counter ends back on the critical word.
        bcnt_en = 1'b1;
        if (bcnt_inc == offset_q) begin
          state_d = wb_tga_i ? ST_INVALIDATE : ST_REFILL;
        end
      end
      ST_REFILL: begin
        fml_stb_o = 1'b1;
        if (fml_ack_i) begin
          // critical word arrives now, a write merges into it.
          tag_we_o    = 1'b1;
          tag_wdata_o = '{valid: 1'b1, dirty: wb_we_i, tag: tag_q};
          data_we_o   = 1'b1;
          if (wb_we_i) begin
            data_wdata_o = merge_lanes(fml_di_i, wb_dat_i, wb_sel_i);
          end
          state_d = ST_REFILL_RUN;
        end
      end
      ST_REFILL_RUN: begin
        bcnt_en   = 1'b1;
        data_we_o = 1'b1;
        // write-first store shows the critical word this cycle.
        if (bcnt_q == offset_q) begin
          wb_ack_o = 1'b1;
        end
        if (bcnt_inc == offset_last) begin
          state_d = ST_IDLE;
        end
      end
      ST_TEST_INV: begin
        state_d = tag_rdata_i.dirty ? ST_EVICT : ST_INVALIDATE;
      end
      ST_INVALIDATE: begin
        tag_we_o    = 1'b1;
        tag_wdata_o = '{valid: 1'b0, dirty: 1'b0, tag: tag_q};
        wb_ack_o    = 1'b1;
        state_d     = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // the fml request stays put until the memory takes it.
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    fml_stb_o && !fml_ack_i |=> fml_stb_o && $stable(fml_adr_o))
    else $error("fml strobe dropped before acknowledge");

  // one acknowledge per wishbone request.
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    wb_ack_o |=> !wb_ack_o)
    else $error("wishbone acknowledge held two cycles");

endmodule

//--- design/fml_cache_pkg.sv
// Cache bridge definitions

package fml_cache_pkg;

  // byte address width of the whole fml space, 64 KiB.
  localparam int FML_DEPTH = 16;

  // byte address width of the cache, 512 bytes.
  localparam int CACHE_DEPTH = 9;

  // one line is one fml burst of 16-bit words.
  localparam int LINE_WORDS = 8;

  // word offset inside a line.
  localparam int OFFSET_W = $clog2(LINE_WORDS);

  // line index, byte bit 0 and the offset sit below it.
  localparam int INDEX_W = CACHE_DEPTH - 1 - OFFSET_W;

  // tag is whatever the cache does not cover.
  localparam int TAG_W = FML_DEPTH - CACHE_DEPTH;

  // data store is addressed by index and offset together.
  localparam int LINE_ADR_W = INDEX_W + OFFSET_W;

  typedef logic [15:0] word_t;
  typedef logic [1:0]  sel_t;

  // wishbone word address, byte bit 0 is not carried.
  typedef logic [FML_DEPTH-2:0] wb_adr_t;

  // fml byte address.
  typedef logic [FML_DEPTH-1:0] fml_adr_t;

  // fields of the wishbone address, tag on top, offset at the bottom.
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // one tag store entry.
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

//--- design/fml_cache_ram.sv
// Write-first store
`timescale 1ns/100ps

module fml_cache_ram #(
  parameter type word_type = logic [15:0],
  parameter int  ADDR_W    = 8
) (
  input  logic              sys_clk,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic              we_i,
  input  word_type          wdata_i,
  output word_type          rdata_o
);

  // one entry per address.
  word_type mem [0:(1 << ADDR_W)-1];

  // read and write share the address port.
  // on a write the new word shows on the output the next cycle.
  always_ff @(posedge sys_clk) begin
    if (we_i) begin
      mem[adr_i] <= wdata_i;
      rdata_o    <= wdata_i;
    end else begin
      rdata_o <= mem[adr_i];
    end
  end

  // a write to an unknown address would corrupt an unknown entry.
  // the address comes from the controller's hold registers and counters.
  assert property (@(posedge sys_clk) we_i |-> !$isunknown(adr_i))
    else $error("store write with unknown address");

endmodule

//--- design/fml_cache_top.sv
// Cache bridge top
`timescale 1ns/100ps

module fml_cache_top (
  input  logic                     sys_clk,
  input  logic                     sys_rst,

  input  fml_cache_pkg::wb_adr_t   wb_adr_i,
  input  fml_cache_pkg::word_t     wb_dat_i,
  input  fml_cache_pkg::sel_t      wb_sel_i,
  input  logic                     wb_we_i,
  input  logic                     wb_tga_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  output fml_cache_pkg::word_t     wb_dat_o,
  output logic                     wb_ack_o,

  output fml_cache_pkg::fml_adr_t  fml_adr_o,
  output logic                     fml_stb_o,
  output logic                     fml_we_o,
  output fml_cache_pkg::word_t     fml_do_o,
  input  logic                     fml_ack_i,
  input  fml_cache_pkg::word_t     fml_di_i
);

  // tag store link.
  fml_cache_pkg::index_t                tag_adr;
  logic                                 tag_we;
  fml_cache_pkg::tag_entry_t            tag_wdata;
  fml_cache_pkg::tag_entry_t            tag_rdata;

  // data store link.
  logic [fml_cache_pkg::LINE_ADR_W-1:0] data_adr;
  logic                                 data_we;
  fml_cache_pkg::word_t                 data_wdata;
  fml_cache_pkg::word_t                 data_rdata;

  fml_cache_ctrl ctrl_inst (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_tga_i     (wb_tga_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .fml_adr_o    (fml_adr_o),
    .fml_stb_o    (fml_stb_o),
    .fml_we_o     (fml_we_o),
    .fml_do_o     (fml_do_o),
    .fml_ack_i    (fml_ack_i),
    .fml_di_i     (fml_di_i),
    .tag_adr_o    (tag_adr),
    .tag_we_o     (tag_we),
    .tag_wdata_o  (tag_wdata),
    .tag_rdata_i  (tag_rdata),
    .data_adr_o   (data_adr),
    .data_we_o    (data_we),
    .data_wdata_o (data_wdata),
    .data_rdata_i (data_rdata)
  );

  // one entry per line, valid, dirty and tag.
  fml_cache_ram #(
    .word_type (fml_cache_pkg::tag_entry_t),
    .ADDR_W    (fml_cache_pkg::INDEX_W)
  ) tag_ram_inst (
    .sys_clk (sys_clk),
    .adr_i   (tag_adr),
    .we_i    (tag_we),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  // one entry per cached word.
  fml_cache_ram #(
    .word_type (fml_cache_pkg::word_t),
    .ADDR_W    (fml_cache_pkg::LINE_ADR_W)
  ) data_ram_inst (
    .sys_clk (sys_clk),
    .adr_i   (data_adr),
    .we_i    (data_we),
    .wdata_i (data_wdata),
    .rdata_o (data_rdata)
  );

endmodule

//--- fml_cache_top.f
design/fml_cache_pkg.sv
design/fml_cache_ram.sv
design/fml_cache_ctrl.sv
design/fml_cache_top.sv
bench/tb_clock_gen.sv
bench/fml_mem_model.sv
bench/fml_cache_tb.sv
